// ==== hdl/isa_pkg.sv ====
// instruction set view of the fetch path
// only what fetch needs to find and carry instructions
package isa_pkg;

    // address and instruction width, rv32
    localparam int unsigned xlen = 32;

    // byte address
    typedef logic [xlen-1:0] addr_t;

    // full instruction word
    typedef logic [31:0] inst_t;

    // one 16-bit parcel, the unit of the compressed extension
    typedef logic [15:0] half_t;

    // addi x0, x0, 0
    // fills the decode slot when nothing valid is there
    localparam inst_t inst_nop = 32'h0000_0013;

    // low field of a 32-bit instruction
    // 00, 01 and 10 mark a compressed parcel
    localparam logic [1:0] rvc_full_code = 2'b11;

endpackage

// ==== hdl/fetch_pkg.sv ====
// fetch hardware view
// line geometry, credit sizes, request fsm
package fetch_pkg;

    // bytes per memory line
    localparam int unsigned line_bytes = 8;

    // credits memory grants after reset
    localparam int unsigned line_credits = 2;

    // one memory line
    typedef logic [8*line_bytes-1:0] line_t;

    // byte offset inside a line
    typedef logic [$clog2(line_bytes)-1:0] line_off_t;

    // credits and outstanding request counts, 0 to line_credits
    typedef logic [1:0] credit_t;

    // buffer line select
    // 0 is the window base, 1 the line after it
    typedef logic slot_t;

    // line request fsm
    // refill and prefetch wait for their own response
    typedef enum logic [1:0] {
        req_idle,
        req_refill,
        req_prefetch
    } req_state_e;

endpackage

// ==== hdl/line_req_ctrl.sv ====
`timescale 1ns/1ps

module line_req_ctrl import isa_pkg::*, fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  addr_t      pc_i,
    input  logic       flush_i,
    input  logic       compressed_i,
    input  logic [1:0] line_valid_i,
    input  addr_t      base_i,
    input  logic       mem_credit_i,
    input  logic       mem_rsp_valid_i,
    output logic       mem_req_o,
    output addr_t      mem_addr_o,
    output logic       wr_en_o,
    output slot_t      wr_slot_o,
    output logic       ready_o
);

    req_state_e state_q;
    req_state_e state_d;
    credit_t    credits_q;
    credit_t    drop_q;
    credit_t    q_cnt_q;
    credit_t    push_idx;
    slot_t      slot_q [2];
    slot_t      req_slot;
    line_off_t  pc_off;
    addr_t      pc_line;
    addr_t      next_line;
    logic       pc_odd;
    logic       in_line0;
    logic       in_line1;
    logic       last_parcel;
    logic       wide;
    logic       hit0;
    logic       hit1;
    logic       need_prefetch;
    logic       need_refill;
    logic       rsp_keep;
    logic       pop;

    assign pc_off    = pc_i[2:0];
    assign pc_odd    = pc_i[0];
    assign pc_line   = pc_i & ~addr_t'(line_bytes - 1);
    assign next_line = base_i + addr_t'(line_bytes);

    // pc line against the two window lines needs a valid base
    assign in_line0    = line_valid_i[0] && (pc_line == base_i);
    assign in_line1    = line_valid_i[0] && (pc_line == next_line);
    assign last_parcel = (pc_off[2:1] == 2'b11);
    assign wide        = !compressed_i;

    // line 0 hit where a wide one at offset 6 also needs line 1
    assign hit0 = in_line0 && (!wide || !last_parcel || line_valid_i[1]);
    // line 1 hit unless a wide one at offset 14 runs past the window
    assign hit1 = in_line1 && line_valid_i[1] && (!wide || !last_parcel);

    // the instruction or its successor reaches into line 1
    assign need_prefetch = !pc_odd && in_line0 && !line_valid_i[1] &&
                           (last_parcel || (pc_off[2:1] == 2'b10 && wide));

    // pc outside the window or the offset 14 straddle
    // a pending prefetch already covers pc in line 1
    assign need_refill = !pc_odd && !in_line0 && !hit1 &&
                         !(in_line1 && state_q == req_prefetch);

    // odd pc needs no memory
    assign ready_o = !flush_i && (pc_odd || hit0 || hit1);

    // one request at a time from idle and only with a credit in hand
    // nothing goes out while in reset
    assign mem_req_o  = !rst && (state_q == req_idle) && !flush_i &&
                        (credits_q != '0) && (need_refill || need_prefetch);
    assign mem_addr_o = need_refill ? pc_line : next_line;
    assign req_slot   = need_refill ? slot_t'(0) : slot_t'(1);

    // responses from before a flush are thrown away
    assign pop      = mem_rsp_valid_i && (drop_q == '0);
    assign rsp_keep = pop && !flush_i;

    assign wr_en_o   = rsp_keep;
    assign wr_slot_o = slot_q[0];

    // new queue tail after this cycle's pop
    assign push_idx = q_cnt_q - credit_t'(pop);

    always_comb begin
        state_d = state_q;
        case (state_q)
            req_idle: begin
                if (mem_req_o) begin
                    state_d = need_refill ? req_refill : req_prefetch;
                end
            end
            req_refill, req_prefetch: begin
                if (rsp_keep) begin
                    state_d = req_idle;
                end
            end
            default: begin
                state_d = req_idle;
            end
        endcase
        if (flush_i) begin
            state_d = req_idle;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= req_idle;
            credits_q <= credit_t'(line_credits);
            drop_q    <= '0;
            q_cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            // spend on request and regain on credit pulse
            credits_q <= credits_q - credit_t'(mem_req_o) + credit_t'(mem_credit_i);
            if (flush_i) begin
                // everything still in flight gets dropped
                drop_q  <= drop_q + q_cnt_q - credit_t'(mem_rsp_valid_i);
                q_cnt_q <= '0;
            end else begin
                if (mem_rsp_valid_i && drop_q != '0) begin
                    drop_q <= drop_q - 2'd1;
                end
                q_cnt_q <= q_cnt_q + credit_t'(mem_req_o) - credit_t'(pop);
            end
        end
    end

    // in-order slot queue with its head at entry 0
    always_ff @(posedge clk) begin
        if (pop) begin
            slot_q[0] <= slot_q[1];
        end
        if (mem_req_o) begin
            slot_q[push_idx[0]] <= req_slot;
        end
    end

endmodule

// ==== hdl/line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer import isa_pkg::*, fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush_i,
    input  logic       wr_en_i,
    input  slot_t      wr_slot_i,
    input  line_t      wr_line_i,
    input  addr_t      refill_base_i,
    output line_t      line0_o,
    output line_t      line1_o,
    output logic [1:0] line_valid_o,
    output addr_t      base_o
);

    line_t      line_q [2];
    logic [1:0] valid_q;
    addr_t      base_q;

    // line data
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            line_q[wr_slot_i] <= wr_line_i;
        end
    end

    // valid bits and window base
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 2'b00;
            base_q  <= '0;
        end else if (flush_i) begin
            valid_q <= 2'b00;
        end else if (wr_en_i) begin
            if (wr_slot_i == slot_t'(0)) begin
                // new base line, the old line 1 no longer follows it
                base_q  <= refill_base_i & ~addr_t'(line_bytes - 1);
                valid_q <= 2'b01;
            end else begin
                valid_q[1] <= 1'b1;
            end
        end
    end

    assign line0_o      = line_q[0];
    assign line1_o      = line_q[1];
    assign line_valid_o = valid_q;
    assign base_o       = base_q;

endmodule

// ==== hdl/inst_aligner.sv ====
`timescale 1ns/1ps

module inst_aligner import isa_pkg::*, fetch_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  addr_t pc_i,
    input  addr_t base_i,
    input  line_t line0_i,
    input  line_t line1_i,
    input  logic  ready_i,
    input  logic  id_stall_i,
    output logic  compressed_o,
    output inst_t inst_o,
    output addr_t inst_pc_o,
    output logic  inst_valid_o,
    output logic  is_compressed_o,
    output logic  trap_misaligned_o
);

    // 16-byte window plus one pad parcel
    // a 32-bit read at the last parcel stays in range
    logic [16*9-1:0] window_ext;
    logic [2:0]      idx;
    line_off_t       pc_off;
    half_t           parcel;
    inst_t           word;
    inst_t           inst_d;
    logic            pc_odd;

    assign pc_off = pc_i[2:0];
    assign pc_odd = pc_i[0];

    // parcel index in the window
    // top bit set when pc sits in the line after the base
    assign idx = {pc_i[3] ^ base_i[3], pc_off[2:1]};

    assign window_ext = {half_t'(0), line1_i, line0_i};

    // at index 3 the word joins the top of line 0 and the bottom of line 1
    assign parcel = window_ext[idx*16 +: 16];
    assign word   = window_ext[idx*16 +: 32];

    // low field tells the width
    assign compressed_o = (parcel[1:0] != rvc_full_code);

    // compressed goes out zero-extended, no expansion here
    always_comb begin
        if (pc_odd) begin
            inst_d = inst_nop;
        end else if (compressed_o) begin
            inst_d = {{(xlen-16){1'b0}}, parcel};
        end else begin
            inst_d = word;
        end
    end

    // decode stage register, holds while decode stalls
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            inst_o            <= inst_nop;
            inst_pc_o         <= '0;
            inst_valid_o      <= 1'b0;
            is_compressed_o   <= 1'b0;
            trap_misaligned_o <= 1'b0;
        end else if (!id_stall_i) begin
            inst_pc_o <= pc_i;
            if (ready_i) begin
                inst_o            <= inst_d;
                inst_valid_o      <= 1'b1;
                is_compressed_o   <= !pc_odd && compressed_o;
                trap_misaligned_o <= pc_odd;
            end else begin
                // bubble while the window fills
                inst_o            <= inst_nop;
                inst_valid_o      <= 1'b0;
                is_compressed_o   <= 1'b0;
                trap_misaligned_o <= 1'b0;
            end
        end
    end

endmodule

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top import isa_pkg::*, fetch_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    // pc source
    input  addr_t pc_i,
    input  logic  flush_i,
    output logic  stall_o,
    // decode
    input  logic  id_stall_i,
    output inst_t inst_o,
    output addr_t inst_pc_o,
    output logic  inst_valid_o,
    output logic  compressed_o,
    output logic  trap_misaligned_o,
    // memory, credit flow control
    output logic  mem_req_o,
    output addr_t mem_addr_o,
    input  logic  mem_credit_i,
    input  logic  mem_rsp_valid_i,
    input  line_t mem_rdata_i
);

    logic       ready;
    logic       parcel_compressed;
    logic       wr_en;
    slot_t      wr_slot;
    logic [1:0] line_valid;
    addr_t      base;
    line_t      line0;
    line_t      line1;

    line_req_ctrl u_line_req_ctrl (
        .clk             (clk),
        .rst             (rst),
        .pc_i            (pc_i),
        .flush_i         (flush_i),
        .compressed_i    (parcel_compressed),
        .line_valid_i    (line_valid),
        .base_i          (base),
        .mem_credit_i    (mem_credit_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_req_o       (mem_req_o),
        .mem_addr_o      (mem_addr_o),
        .wr_en_o         (wr_en),
        .wr_slot_o       (wr_slot),
        .ready_o         (ready)
    );

    // pc is held while a refill is pending, so it names the refilled line
    line_buffer u_line_buffer (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (flush_i),
        .wr_en_i       (wr_en),
        .wr_slot_i     (wr_slot),
        .wr_line_i     (mem_rdata_i),
        .refill_base_i (pc_i),
        .line0_o       (line0),
        .line1_o       (line1),
        .line_valid_o  (line_valid),
        .base_o        (base)
    );

    inst_aligner u_inst_aligner (
        .clk               (clk),
        .rst               (rst),
        .pc_i              (pc_i),
        .base_i            (base),
        .line0_i           (line0),
        .line1_i           (line1),
        .ready_i           (ready),
        .id_stall_i        (id_stall_i),
        .compressed_o      (parcel_compressed),
        .inst_o            (inst_o),
        .inst_pc_o         (inst_pc_o),
        .inst_valid_o      (inst_valid_o),
        .is_compressed_o   (compressed_o),
        .trap_misaligned_o (trap_misaligned_o)
    );

    // pc source waits until the instruction is all there
    assign stall_o = ~ready;

endmodule

// ==== sim/fetch_model.svh ====
`ifndef fetch_model_svh
`define fetch_model_svh

// memory model, program image and expected instruction
// included inside tb_fetch, shares its signals and error counters

localparam int          lat_min     = 1;
localparam int          lat_max     = 4;
localparam int          mem_credits = 2;
// addi x0, x0, 0
localparam logic [31:0] nop_word    = 32'h0000_0013;

// outstanding requests, oldest first
logic [31:0] rsp_addr_q[$];
int          rsp_due_q[$];
// credit pulses still owed to the dut
int          credit_due_q[$];
int          model_credits;
int          req_count;
int          rsp_count;
int          last_rsp_due;
int          last_credit_due;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// parcel at a halfword address
// about half of them open a 32-bit instruction
function automatic logic [15:0] image_parcel(input logic [31:0] addr);
    logic [31:0] h;
    h = xorshift32(((addr >> 1) * 32'h9e37_79b9) ^ seed);
    h = xorshift32(h);
    if (h[16]) begin
        return {h[15:2], 2'b11};
    end
    // keep the other half compressed
    if (h[1:0] == 2'b11) begin
        return {h[15:2], 2'b10};
    end
    return h[15:0];
endfunction

// little endian, parcel 0 in the low bits
function automatic logic [63:0] line_data(input logic [31:0] addr);
    logic [31:0] a;
    a = addr & ~32'd7;
    return {image_parcel(a + 32'd6), image_parcel(a + 32'd4),
            image_parcel(a + 32'd2), image_parcel(a)};
endfunction

function automatic logic expected_compressed(input logic [31:0] pc);
    logic [15:0] lo;
    lo = image_parcel(pc);
    return !pc[0] && (lo[1:0] != 2'b11);
endfunction

function automatic logic [31:0] expected_size(input logic [31:0] pc);
    return expected_compressed(pc) ? 32'd2 : 32'd4;
endfunction

// compressed parcels leave zero-extended, odd pc gives the nop
function automatic logic [31:0] expected_inst(input logic [31:0] pc);
    logic [15:0] lo;
    if (pc[0]) begin
        return nop_word;
    end
    lo = image_parcel(pc);
    if (lo[1:0] != 2'b11) begin
        return {16'h0000, lo};
    end
    return {image_parcel(pc + 32'd2), lo};
endfunction

// request seen before the edge, the dut spends its credit at that edge
task automatic accept_request();
    int lat;
    assert (model_credits > 0) else begin
        other_errs++;
        $display("memory request at %0t issued with no credit left", $time);
    end
    assert (mem_addr_o[2:0] == 3'b000) else begin
        other_errs++;
        $display("memory request address %h is not line aligned", mem_addr_o);
    end
    model_credits--;
    req_count++;
    lat = lat_min + int'(rand32() % (lat_max - lat_min + 1));
    // in order, one response per cycle
    last_rsp_due = (cyc + lat > last_rsp_due) ? cyc + lat : last_rsp_due + 1;
    rsp_addr_q.push_back(mem_addr_o);
    rsp_due_q.push_back(last_rsp_due);
endtask

task automatic drive_memory();
    int gap;
    // last cycle's pulse was counted by the dut at the edge
    if (mem_credit_i) begin
        model_credits++;
    end
    mem_credit_i    = 1'b0;
    mem_rsp_valid_i = 1'b0;
    if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cyc) begin
        mem_rsp_valid_i = 1'b1;
        mem_rdata_i     = line_data(rsp_addr_q[0]);
        rsp_addr_q.delete(0);
        rsp_due_q.delete(0);
        rsp_count++;
        // credit comes back 0 to 3 cycles after the line
        gap = int'(rand32() % 4);
        last_credit_due = (cyc + gap > last_credit_due) ? cyc + gap : last_credit_due + 1;
        credit_due_q.push_back(last_credit_due);
    end
    if (credit_due_q.size() != 0 && credit_due_q[0] <= cyc) begin
        mem_credit_i = 1'b1;
        credit_due_q.delete(0);
    end
endtask

function automatic logic traffic_pending();
    return (rsp_due_q.size() != 0) || (credit_due_q.size() != 0) || mem_credit_i;
endfunction

task automatic check_memory_totals();
    assert (rsp_count == req_count) else begin
        other_errs++;
        $display("memory answered %0d times for %0d requests", rsp_count, req_count);
    end
    assert (model_credits == mem_credits) else begin
        other_errs++;
        $display("memory holds %0d credits at the end, not all came back", model_credits);
    end
endtask

`endif

// ==== sim/tb_fetch.sv ====
`timescale 1ns/1ps

module tb_fetch;

    localparam int          clk_period  = 40;
    localparam logic [31:0] seed        = 32'h46a3;
    // accepted instructions before the drain
    localparam int          n_insts     = 400;
    // worst case cycles per instruction with flush, refill and prefetch
    localparam int          step_cycles = 40;
    localparam int          watchdog_ns = (n_insts * step_cycles + 8) * clk_period;

    logic        clk;
    logic        rst;
    logic [31:0] pc_i;
    logic        flush_i;
    logic        stall_o;
    logic        id_stall_i;
    logic [31:0] inst_o;
    logic [31:0] inst_pc_o;
    logic        inst_valid_o;
    logic        compressed_o;
    logic        trap_misaligned_o;
    logic        mem_req_o;
    logic [31:0] mem_addr_o;
    logic        mem_credit_i;
    logic        mem_rsp_valid_i;
    logic [63:0] mem_rdata_i;

    logic [31:0] rng_state;
    int          value_errs;
    int          other_errs;
    int          n_taken;
    int          n_checked;
    int          cyc;
    // what the last rising edge did
    logic        last_take;
    logic        last_hold;
    logic [31:0] held_inst;
    logic [31:0] held_pc;
    logic        held_valid;
    logic [31:0] exp_pc_q[$];
    logic [31:0] exp_inst_q[$];

    `include "fetch_model.svh"

    fetch_top u_fetch_top (
        .clk               (clk),
        .rst               (rst),
        .pc_i              (pc_i),
        .flush_i           (flush_i),
        .stall_o           (stall_o),
        .id_stall_i        (id_stall_i),
        .inst_o            (inst_o),
        .inst_pc_o         (inst_pc_o),
        .inst_valid_o      (inst_valid_o),
        .compressed_o      (compressed_o),
        .trap_misaligned_o (trap_misaligned_o),
        .mem_req_o         (mem_req_o),
        .mem_addr_o        (mem_addr_o),
        .mem_credit_i      (mem_credit_i),
        .mem_rsp_valid_i   (mem_rsp_valid_i),
        .mem_rdata_i       (mem_rdata_i)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // even jump target in the low 1 KiB
    function automatic logic [31:0] next_target();
        return rand32() & 32'h0000_03fe;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            value_errs++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // registered outputs are stable at the falling edge
    task automatic check_outputs();
        logic [31:0] pc;
        logic [31:0] inst;
        if (last_hold) begin
            // decode stalled so nothing may move
            compare_field("inst_o", inst_o, held_inst);
            compare_field("inst_pc_o", inst_pc_o, held_pc);
            compare_field("inst_valid_o", 32'(inst_valid_o), 32'(held_valid));
        end else if (last_take) begin
            pc   = exp_pc_q.pop_front();
            inst = exp_inst_q.pop_front();
            compare_field("inst_valid_o", 32'(inst_valid_o), 32'd1);
            compare_field("inst_pc_o", inst_pc_o, pc);
            compare_field("inst_o", inst_o, inst);
            compare_field("compressed_o", 32'(compressed_o), 32'(expected_compressed(pc)));
            compare_field("trap_misaligned_o", 32'(trap_misaligned_o), 32'(pc[0]));
            n_checked++;
        end else begin
            // window not ready gives a bubble
            compare_field("inst_valid_o", 32'(inst_valid_o), 32'd0);
        end
        held_inst  = inst_o;
        held_pc    = inst_pc_o;
        held_valid = inst_valid_o;
    endtask

    // pc source and decode side
    task automatic drive_inputs(input logic busy);
        logic [31:0] r;
        r          = rand32();
        flush_i    = 1'b0;
        id_stall_i = busy && (r[3:0] == 4'd0);
        if (busy && r[9:5] == 5'd0) begin
            // redirect while lines may still be in flight
            flush_i = 1'b1;
            pc_i    = next_target();
        end else if (last_take) begin
            if (pc_i[0]) begin
                // misaligned trap taken so jump back to even code
                flush_i = 1'b1;
                pc_i    = next_target();
            end else if (busy) begin
                // now and then a step lands on an odd pc
                pc_i = pc_i + expected_size(pc_i) + ((r[15:11] == 5'd0) ? 32'd1 : 32'd0);
            end
        end
    endtask

    // inputs have settled and hold until the rising edge
    task automatic sample_cycle();
        last_hold = id_stall_i;
        last_take = !stall_o && !id_stall_i;
        if (last_take) begin
            exp_pc_q.push_back(pc_i);
            exp_inst_q.push_back(expected_inst(pc_i));
            n_taken++;
        end
        assert (!(pc_i[0] && mem_req_o)) else begin
            other_errs++;
            $display("memory request at %0t for odd pc %h", $time, pc_i);
        end
        if (mem_req_o) begin
            accept_request();
        end
    endtask

    task automatic run_cycle(input logic busy);
        @(negedge clk);
        cyc++;
        check_outputs();
        drive_memory();
        drive_inputs(busy);
        #1;
        sample_cycle();
    endtask

    task automatic report_counts();
        $display("checked %0d instructions, %0d value errors, %0d other errors",
                 n_checked, value_errs, other_errs);
    endtask

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        pc_i            = '0;
        flush_i         = 1'b0;
        id_stall_i      = 1'b0;
        mem_credit_i    = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rdata_i     = '0;
        rng_state       = seed;
        value_errs      = 0;
        other_errs      = 0;
        n_taken         = 0;
        n_checked       = 0;
        cyc             = 0;
        last_take       = 1'b0;
        last_hold       = 1'b0;
        held_inst       = '0;
        held_pc         = '0;
        held_valid      = 1'b0;
        model_credits   = mem_credits;
        req_count       = 0;
        rsp_count       = 0;
        last_rsp_due    = 0;
        last_credit_due = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        assert (stall_o && !mem_req_o && !inst_valid_o && !trap_misaligned_o &&
                inst_o == nop_word) else begin
            other_errs++;
            $display("outputs are not in their reset state at %0t", $time);
        end
        rst = 1'b0;
        #1;
        sample_cycle();
        while (n_taken < n_insts) begin
            run_cycle(1'b1);
        end
        // pc held while memory traffic and credits settle
        do begin
            run_cycle(1'b0);
        end while (traffic_pending() || stall_o);
        check_memory_totals();
        report_counts();
        if (value_errs == 0 && other_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // hang guard
    initial begin
        #(watchdog_ns);
        $display("timeout after %0d ns, the run did not finish", watchdog_ns);
        report_counts();
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+sim
hdl/isa_pkg.sv
hdl/fetch_pkg.sv
hdl/line_req_ctrl.sv
hdl/line_buffer.sv
hdl/inst_aligner.sv
hdl/fetch_top.sv
sim/tb_fetch.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the fetch testbench with verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch -f files.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_fetch > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$log"; then
    exit 1
fi
exit 0
